//--- common/collision_pkg.sv
`default_nettype none

package collision_pkg;

    // Field widths of the fixed-point formats
    localparam int POS_W   = 32;
    localparam int AXIS_W  = 16;
    localparam int POINT_W = 22;
    localparam int HALF_W  = 7;
    localparam int DOT_W   = 38;
    localparam int FIXED_W = 32;

    // Centre scaling before the corner offset is formed
    localparam int POS_SHIFT = 10;

    // Dot product down to the projected fixed format
    localparam int PROJ_SHIFT = 4;

    // Half sizes up to the projected fixed format
    localparam int HALF_SHIFT = 24;

    localparam int NUM_CORNERS = 4;

    // Box centre coordinate
    typedef logic signed [POS_W-1:0] pos_t;

    // Unit axis or normal component
    typedef logic signed [AXIS_W-1:0] axis_t;

    // Corner coordinate, also a centre once scaled down
    typedef logic signed [POINT_W-1:0] point_t;

    // Half width or half height
    typedef logic signed [HALF_W-1:0] half_t;

    // Full precision corner offset dotted with an axis
    typedef logic signed [DOT_W-1:0] dot_t;

    // Projected coordinate or penetration
    typedef logic signed [FIXED_W-1:0] fixed_t;

endpackage

`default_nettype wire

//--- projection/obb_projector.sv
`timescale 1ns/100ps
`default_nettype none

module obb_projector (
    input  logic                  clk,
    input  logic                  load,
    input  logic                  pass_b,
    input  collision_pkg::pos_t   obb1_pos_x, obb1_pos_y,
    input  collision_pkg::axis_t  obb1_u_x, obb1_u_y, obb1_v_x, obb1_v_y,
    input  collision_pkg::point_t obb1_point0_x, obb1_point0_y, obb1_point1_x, obb1_point1_y,
    input  collision_pkg::point_t obb1_point2_x, obb1_point2_y, obb1_point3_x, obb1_point3_y,
    input  collision_pkg::half_t  obb1_half_width, obb1_half_height,
    input  collision_pkg::pos_t   obb2_pos_x, obb2_pos_y,
    input  collision_pkg::axis_t  obb2_u_x, obb2_u_y, obb2_v_x, obb2_v_y,
    input  collision_pkg::point_t obb2_point0_x, obb2_point0_y, obb2_point1_x, obb2_point1_y,
    input  collision_pkg::point_t obb2_point2_x, obb2_point2_y, obb2_point3_x, obb2_point3_y,
    input  collision_pkg::half_t  obb2_half_width, obb2_half_height,
    output collision_pkg::fixed_t min_u, max_u, min_v, max_v,
    output collision_pkg::half_t  ref_half_width, ref_half_height,
    output collision_pkg::axis_t  ref_u_x, ref_u_y, ref_v_x, ref_v_y
);
    import collision_pkg::*;

    // Index 0 holds box 1, index 1 holds box 2
    pos_t   pos_x_q [2];
    pos_t   pos_y_q [2];
    axis_t  u_x_q [2];
    axis_t  u_y_q [2];
    axis_t  v_x_q [2];
    axis_t  v_y_q [2];
    point_t pt_x_q [2][NUM_CORNERS];
    point_t pt_y_q [2][NUM_CORNERS];
    half_t  hw_q [2];
    half_t  hh_q [2];

    always_ff @(posedge clk) begin
        if (load) begin
            pos_x_q <= '{obb1_pos_x, obb2_pos_x};
            pos_y_q <= '{obb1_pos_y, obb2_pos_y};
            u_x_q   <= '{obb1_u_x, obb2_u_x};
            u_y_q   <= '{obb1_u_y, obb2_u_y};
            v_x_q   <= '{obb1_v_x, obb2_v_x};
            v_y_q   <= '{obb1_v_y, obb2_v_y};
            pt_x_q[0] <= '{obb1_point0_x, obb1_point1_x, obb1_point2_x, obb1_point3_x};
            pt_y_q[0] <= '{obb1_point0_y, obb1_point1_y, obb1_point2_y, obb1_point3_y};
            pt_x_q[1] <= '{obb2_point0_x, obb2_point1_x, obb2_point2_x, obb2_point3_x};
            pt_y_q[1] <= '{obb2_point0_y, obb2_point1_y, obb2_point2_y, obb2_point3_y};
            hw_q    <= '{obb1_half_width, obb2_half_width};
            hh_q    <= '{obb1_half_height, obb2_half_height};
        end
    end

    // Pass A projects box 1 onto box 2, pass B the other way round
    logic   src;
    logic   dst;
    point_t ctr_x;
    point_t ctr_y;

    assign src   = pass_b;
    assign dst   = ~pass_b;
    assign ctr_x = point_t'(pos_x_q[dst] >>> POS_SHIFT);
    assign ctr_y = point_t'(pos_y_q[dst] >>> POS_SHIFT);

    fixed_t proj_u [NUM_CORNERS];
    fixed_t proj_v [NUM_CORNERS];

    for (genvar i = 0; i < NUM_CORNERS; i++) begin : g_corner
        point_t rel_x;
        point_t rel_y;
        dot_t   dot_u;
        dot_t   dot_v;

        assign rel_x = pt_x_q[src][i] - ctr_x;
        assign rel_y = pt_y_q[src][i] - ctr_y;
        assign dot_u = dot_t'(rel_x) * dot_t'(u_x_q[dst]) + dot_t'(rel_y) * dot_t'(u_y_q[dst]);
        assign dot_v = dot_t'(rel_x) * dot_t'(v_x_q[dst]) + dot_t'(rel_y) * dot_t'(v_y_q[dst]);
        assign proj_u[i] = fixed_t'(dot_u >>> PROJ_SHIFT);
        assign proj_v[i] = fixed_t'(dot_v >>> PROJ_SHIFT);
    end

    fixed_t lo_u;
    fixed_t hi_u;
    fixed_t lo_v;
    fixed_t hi_v;

    always_comb begin
        lo_u = proj_u[0];
        hi_u = proj_u[0];
        lo_v = proj_v[0];
        hi_v = proj_v[0];
        for (int i = 1; i < NUM_CORNERS; i++) begin
            if (proj_u[i] < lo_u) lo_u = proj_u[i];
            if (proj_u[i] > hi_u) hi_u = proj_u[i];
            if (proj_v[i] < lo_v) lo_v = proj_v[i];
            if (proj_v[i] > hi_v) hi_v = proj_v[i];
        end
    end

    // Extents go out with the reference box they were measured against
    always_ff @(posedge clk) begin
        min_u           <= lo_u;
        max_u           <= hi_u;
        min_v           <= lo_v;
        max_v           <= hi_v;
        ref_half_width  <= hw_q[dst];
        ref_half_height <= hh_q[dst];
        ref_u_x         <= u_x_q[dst];
        ref_u_y         <= u_y_q[dst];
        ref_v_x         <= v_x_q[dst];
        ref_v_y         <= v_y_q[dst];
    end

endmodule

`default_nettype wire

//--- projection/axis_penetration.sv
`timescale 1ns/100ps
`default_nettype none

module axis_penetration (
    input  collision_pkg::fixed_t min_u,
    input  collision_pkg::fixed_t max_u,
    input  collision_pkg::fixed_t min_v,
    input  collision_pkg::fixed_t max_v,
    input  collision_pkg::half_t  ref_half_width,
    input  collision_pkg::half_t  ref_half_height,
    input  collision_pkg::axis_t  ref_u_x,
    input  collision_pkg::axis_t  ref_u_y,
    input  collision_pkg::axis_t  ref_v_x,
    input  collision_pkg::axis_t  ref_v_y,
    output collision_pkg::fixed_t pen_u,
    output collision_pkg::fixed_t pen_v,
    output collision_pkg::axis_t  norm_u_x,
    output collision_pkg::axis_t  norm_u_y,
    output collision_pkg::axis_t  norm_v_x,
    output collision_pkg::axis_t  norm_v_y
);
    import collision_pkg::*;

    // Half sizes in the projected format
    fixed_t half_w_fx;
    fixed_t half_h_fx;

    assign half_w_fx = fixed_t'(ref_half_width) <<< HALF_SHIFT;
    assign half_h_fx = fixed_t'(ref_half_height) <<< HALF_SHIFT;

    fixed_t pen_min_u;
    fixed_t pen_max_u;
    fixed_t pen_min_v;
    fixed_t pen_max_v;

    assign pen_min_u = half_w_fx - min_u;
    assign pen_max_u = max_u + half_w_fx;
    assign pen_min_v = half_h_fx - min_v;
    assign pen_max_v = max_v + half_h_fx;

    // Max side only wins when strictly shallower
    always_comb begin
        if (pen_max_u < pen_min_u) begin
            pen_u    = pen_max_u;
            norm_u_x = ref_u_x;
            norm_u_y = ref_u_y;
        end else begin
            pen_u    = pen_min_u;
            norm_u_x = axis_t'(-ref_u_x);
            norm_u_y = axis_t'(-ref_u_y);
        end
    end

    always_comb begin
        if (pen_max_v < pen_min_v) begin
            pen_v    = pen_max_v;
            norm_v_x = ref_v_x;
            norm_v_y = ref_v_y;
        end else begin
            pen_v    = pen_min_v;
            norm_v_x = axis_t'(-ref_v_x);
            norm_v_y = axis_t'(-ref_v_y);
        end
    end

endmodule

`default_nettype wire

//--- design/contact_select.sv
`timescale 1ns/100ps
`default_nettype none

module contact_select (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  keep_a,
    input  logic                  merge,
    input  collision_pkg::fixed_t pen_u,
    input  collision_pkg::fixed_t pen_v,
    input  collision_pkg::axis_t  norm_u_x,
    input  collision_pkg::axis_t  norm_u_y,
    input  collision_pkg::axis_t  norm_v_x,
    input  collision_pkg::axis_t  norm_v_y,
    output logic                  is_collision,
    output collision_pkg::fixed_t penetration,
    output collision_pkg::axis_t  normal_x,
    output collision_pkg::axis_t  normal_y
);
    import collision_pkg::*;

    // Pass A candidates, held until pass B arrives
    fixed_t a_pen_u;
    fixed_t a_pen_v;
    axis_t  a_nu_x;
    axis_t  a_nu_y;
    axis_t  a_nv_x;
    axis_t  a_nv_y;

    always_ff @(posedge clk) begin
        if (keep_a) begin
            a_pen_u <= pen_u;
            a_pen_v <= pen_v;
            a_nu_x  <= norm_u_x;
            a_nu_y  <= norm_u_y;
            a_nv_x  <= norm_v_x;
            a_nv_y  <= norm_v_y;
        end
    end

    fixed_t sel_pen_u;
    fixed_t sel_pen_v;
    fixed_t fin_pen;
    axis_t  sel_nu_x;
    axis_t  sel_nu_y;
    axis_t  sel_nv_x;
    axis_t  sel_nv_y;
    axis_t  fin_n_x;
    axis_t  fin_n_y;

    // Ties keep pass A, then keep u over v
    always_comb begin
        sel_pen_u = a_pen_u;
        sel_nu_x  = a_nu_x;
        sel_nu_y  = a_nu_y;
        if (pen_u < a_pen_u) begin
            sel_pen_u = pen_u;
            sel_nu_x  = norm_u_x;
            sel_nu_y  = norm_u_y;
        end

        sel_pen_v = a_pen_v;
        sel_nv_x  = a_nv_x;
        sel_nv_y  = a_nv_y;
        if (pen_v < a_pen_v) begin
            sel_pen_v = pen_v;
            sel_nv_x  = norm_v_x;
            sel_nv_y  = norm_v_y;
        end

        fin_pen = sel_pen_u;
        fin_n_x = sel_nu_x;
        fin_n_y = sel_nu_y;
        if (sel_pen_v < sel_pen_u) begin
            fin_pen = sel_pen_v;
            fin_n_x = sel_nv_x;
            fin_n_y = sel_nv_y;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            is_collision <= 1'b0;
            penetration  <= '0;
            normal_x     <= '0;
            normal_y     <= '0;
        end else if (merge) begin
            // Non-negative overlap means the boxes touch
            is_collision <= ~fin_pen[FIXED_W-1];
            penetration  <= fin_pen;
            normal_x     <= fin_n_x;
            normal_y     <= fin_n_y;
        end
    end

endmodule

`default_nettype wire

//--- design/collision_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module collision_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    input  logic out_ready,
    output logic in_ready,
    output logic load,
    output logic keep_a,
    output logic merge,
    output logic pass_b,
    output logic out_valid
);

    typedef enum logic [2:0] {
        idle,
        project_a,
        project_b,
        resolve,
        hold
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (in_valid) state_next = project_a;
            end
            // Pass A extents register at the end of this state
            project_a: state_next = project_b;
            project_b: state_next = resolve;
            resolve:   state_next = hold;
            hold: begin
                if (out_ready) state_next = idle;
            end
            default:   state_next = idle;
        endcase
    end

    // One request in flight at a time
    assign in_ready = (state == idle);

    // Boxes are sampled on the accepting edge itself
    assign load = in_ready & in_valid;

    // Swap roles while pass A candidates are stored
    assign pass_b = (state == project_b);
    assign keep_a = (state == project_b);

    // Pass B extents are visible during resolve
    assign merge = (state == resolve);

    assign out_valid = (state == hold);

endmodule

`default_nettype wire

//--- design/collision_detector.sv
`timescale 1ns/100ps
`default_nettype none

module collision_detector (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  collision_pkg::pos_t   obb1_pos_x, obb1_pos_y,
    input  collision_pkg::axis_t  obb1_u_x, obb1_u_y, obb1_v_x, obb1_v_y,
    input  collision_pkg::point_t obb1_point0_x, obb1_point0_y, obb1_point1_x, obb1_point1_y,
    input  collision_pkg::point_t obb1_point2_x, obb1_point2_y, obb1_point3_x, obb1_point3_y,
    input  collision_pkg::half_t  obb1_half_width, obb1_half_height,
    input  collision_pkg::pos_t   obb2_pos_x, obb2_pos_y,
    input  collision_pkg::axis_t  obb2_u_x, obb2_u_y, obb2_v_x, obb2_v_y,
    input  collision_pkg::point_t obb2_point0_x, obb2_point0_y, obb2_point1_x, obb2_point1_y,
    input  collision_pkg::point_t obb2_point2_x, obb2_point2_y, obb2_point3_x, obb2_point3_y,
    input  collision_pkg::half_t  obb2_half_width, obb2_half_height,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic                  is_collision,
    output collision_pkg::axis_t  normal_x,
    output collision_pkg::axis_t  normal_y,
    output collision_pkg::fixed_t penetration
);
    import collision_pkg::*;

    logic   load;
    logic   pass_b;
    logic   keep_a;
    logic   merge;
    fixed_t min_u;
    fixed_t max_u;
    fixed_t min_v;
    fixed_t max_v;
    half_t  ref_half_width;
    half_t  ref_half_height;
    axis_t  ref_u_x;
    axis_t  ref_u_y;
    axis_t  ref_v_x;
    axis_t  ref_v_y;
    fixed_t pen_u;
    fixed_t pen_v;
    axis_t  norm_u_x;
    axis_t  norm_u_y;
    axis_t  norm_v_x;
    axis_t  norm_v_y;

    collision_ctrl u_ctrl (
        .clk, .reset, .in_valid, .out_ready, .in_ready,
        .load, .keep_a, .merge, .pass_b, .out_valid
    );

    // Shared by both passes
    obb_projector u_projector (
        .clk, .load, .pass_b,
        .obb1_pos_x, .obb1_pos_y, .obb1_u_x, .obb1_u_y, .obb1_v_x, .obb1_v_y,
        .obb1_point0_x, .obb1_point0_y, .obb1_point1_x, .obb1_point1_y,
        .obb1_point2_x, .obb1_point2_y, .obb1_point3_x, .obb1_point3_y,
        .obb1_half_width, .obb1_half_height,
        .obb2_pos_x, .obb2_pos_y, .obb2_u_x, .obb2_u_y, .obb2_v_x, .obb2_v_y,
        .obb2_point0_x, .obb2_point0_y, .obb2_point1_x, .obb2_point1_y,
        .obb2_point2_x, .obb2_point2_y, .obb2_point3_x, .obb2_point3_y,
        .obb2_half_width, .obb2_half_height,
        .min_u, .max_u, .min_v, .max_v, .ref_half_width, .ref_half_height,
        .ref_u_x, .ref_u_y, .ref_v_x, .ref_v_y
    );

    axis_penetration u_penetration (
        .min_u, .max_u, .min_v, .max_v, .ref_half_width, .ref_half_height,
        .ref_u_x, .ref_u_y, .ref_v_x, .ref_v_y,
        .pen_u, .pen_v, .norm_u_x, .norm_u_y, .norm_v_x, .norm_v_y
    );

    contact_select u_select (
        .clk, .reset, .keep_a, .merge,
        .pen_u, .pen_v, .norm_u_x, .norm_u_y, .norm_v_x, .norm_v_y,
        .is_collision, .penetration, .normal_x, .normal_y
    );

endmodule

`default_nettype wire

//--- verif/collision_ref.svh
`ifndef COLLISION_REF_SVH
`define COLLISION_REF_SVH

// One box of a request, as the DUT ports carry it
typedef struct packed {
    pos_t                        pos_x;
    pos_t                        pos_y;
    axis_t                       u_x;
    axis_t                       u_y;
    axis_t                       v_x;
    axis_t                       v_y;
    point_t [NUM_CORNERS-1:0]    pt_x;
    point_t [NUM_CORNERS-1:0]    pt_y;
    half_t                       hw;
    half_t                       hh;
} box_t;

typedef struct packed {
    logic   coll;
    fixed_t pen;
    axis_t  nx;
    axis_t  ny;
} contact_t;

// Corners of src against the axes and centre of dst
function automatic void project_sides(input box_t src, input box_t dst,
                                      output fixed_t pu, output axis_t nux, output axis_t nuy,
                                      output fixed_t pv, output axis_t nvx, output axis_t nvy);
    pos_t   p_shift;
    point_t cx;
    point_t cy;
    point_t rx;
    point_t ry;
    dot_t   dx;
    dot_t   dy;
    dot_t   du;
    dot_t   dv;
    fixed_t prj_u;
    fixed_t prj_v;
    fixed_t lo_u;
    fixed_t hi_u;
    fixed_t lo_v;
    fixed_t hi_v;
    half_t  h;
    fixed_t half_w;
    fixed_t half_h;
    fixed_t pmin;
    fixed_t pmax;
    p_shift = dst.pos_x >>> POS_SHIFT;
    cx = p_shift[POINT_W-1:0];
    p_shift = dst.pos_y >>> POS_SHIFT;
    cy = p_shift[POINT_W-1:0];
    for (int i = 0; i < NUM_CORNERS; i++) begin
        rx = src.pt_x[i] - cx;
        ry = src.pt_y[i] - cy;
        dx = {{(DOT_W-POINT_W){rx[POINT_W-1]}}, rx};
        dy = {{(DOT_W-POINT_W){ry[POINT_W-1]}}, ry};
        du = dx * dot_t'(dst.u_x) + dy * dot_t'(dst.u_y);
        dv = dx * dot_t'(dst.v_x) + dy * dot_t'(dst.v_y);
        du = du >>> PROJ_SHIFT;
        dv = dv >>> PROJ_SHIFT;
        prj_u = du[FIXED_W-1:0];
        prj_v = dv[FIXED_W-1:0];
        if (i == 0 || prj_u < lo_u) lo_u = prj_u;
        if (i == 0 || prj_u > hi_u) hi_u = prj_u;
        if (i == 0 || prj_v < lo_v) lo_v = prj_v;
        if (i == 0 || prj_v > hi_v) hi_v = prj_v;
    end
    h = dst.hw;
    half_w = {{(FIXED_W-HALF_W){h[HALF_W-1]}}, h};
    half_w = half_w <<< HALF_SHIFT;
    h = dst.hh;
    half_h = {{(FIXED_W-HALF_W){h[HALF_W-1]}}, h};
    half_h = half_h <<< HALF_SHIFT;
    // Max side only when strictly smaller
    pmin = half_w - lo_u;
    pmax = hi_u + half_w;
    pu  = (pmax < pmin) ? pmax : pmin;
    nux = (pmax < pmin) ? dst.u_x : -dst.u_x;
    nuy = (pmax < pmin) ? dst.u_y : -dst.u_y;
    pmin = half_h - lo_v;
    pmax = hi_v + half_h;
    pv  = (pmax < pmin) ? pmax : pmin;
    nvx = (pmax < pmin) ? dst.v_x : -dst.v_x;
    nvy = (pmax < pmin) ? dst.v_y : -dst.v_y;
endfunction

function automatic contact_t expected_contact(input box_t b1, input box_t b2);
    fixed_t   au;
    fixed_t   av;
    fixed_t   bu;
    fixed_t   bv;
    axis_t    a_n [4];
    axis_t    b_n [4];
    contact_t c;
    project_sides(b1, b2, au, a_n[0], a_n[1], av, a_n[2], a_n[3]);
    project_sides(b2, b1, bu, b_n[0], b_n[1], bv, b_n[2], b_n[3]);
    // Pass B replaces pass A only when strictly smaller
    if (bu < au) begin
        au = bu;
        a_n[0] = b_n[0];
        a_n[1] = b_n[1];
    end
    if (bv < av) begin
        av = bv;
        a_n[2] = b_n[2];
        a_n[3] = b_n[3];
    end
    c.pen = (av < au) ? av : au;
    c.nx  = (av < au) ? a_n[2] : a_n[0];
    c.ny  = (av < au) ? a_n[3] : a_n[1];
    c.coll = (c.pen >= 0);
    return c;
endfunction

`endif

//--- verif/tb_collision_detector.sv
`timescale 1ns/100ps
`default_nettype none

module tb_collision_detector;
    import collision_pkg::*;

    `include "collision_ref.svh"

    localparam int NUM_RANDOM  = 200;
    localparam int NUM_VECTORS = NUM_RANDOM + 3;
    localparam int MAX_CYCLES  = NUM_VECTORS * 16 + 100;

    logic   clk;
    logic   reset;
    logic   in_valid;
    logic   in_ready;
    logic   out_valid;
    logic   out_ready;
    logic   is_collision;
    axis_t  normal_x;
    axis_t  normal_y;
    fixed_t penetration;
    pos_t   obb1_pos_x, obb1_pos_y, obb2_pos_x, obb2_pos_y;
    axis_t  obb1_u_x, obb1_u_y, obb1_v_x, obb1_v_y;
    axis_t  obb2_u_x, obb2_u_y, obb2_v_x, obb2_v_y;
    point_t obb1_point0_x, obb1_point0_y, obb1_point1_x, obb1_point1_y;
    point_t obb1_point2_x, obb1_point2_y, obb1_point3_x, obb1_point3_y;
    point_t obb2_point0_x, obb2_point0_y, obb2_point1_x, obb2_point1_y;
    point_t obb2_point2_x, obb2_point2_y, obb2_point3_x, obb2_point3_y;
    half_t  obb1_half_width, obb1_half_height, obb2_half_width, obb2_half_height;

    integer   seed = 32'hc297_d0a8;
    int       errors = 0;
    int       pass_count = 0;
    int       fail_count = 0;
    int       done_count = 0;
    int       cycles = 0;
    contact_t exp_q [$];
    string    name_q [$];

    collision_detector u_dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Simulation timed out after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_fixed(input fixed_t got, input fixed_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_axis(input axis_t got, input axis_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic box_t random_box();
        box_t        b;
        logic [31:0] w;
        b.pos_x = rand_word();
        b.pos_y = rand_word();
        w = rand_word();
        b.u_x = w[15:0];
        b.u_y = w[31:16];
        w = rand_word();
        b.v_x = w[15:0];
        b.v_y = w[31:16];
        for (int i = 0; i < NUM_CORNERS; i++) begin
            w = rand_word();
            b.pt_x[i] = w[POINT_W-1:0];
            w = rand_word();
            b.pt_y[i] = w[POINT_W-1:0];
        end
        w = rand_word();
        b.hw = w[HALF_W-1:0];
        b.hh = w[HALF_W+7:8];
        return b;
    endfunction

    // Axis-aligned square, one unit is 2^14 in corner coordinates
    function automatic box_t aligned_box(input int cx, input int cy, input int h);
        box_t b;
        b.pos_x = cx * (1 << 24);
        b.pos_y = cy * (1 << 24);
        b.u_x = 16'sh4000;
        b.u_y = '0;
        b.v_x = '0;
        b.v_y = 16'sh4000;
        b.pt_x = {point_t'((cx - h) * 16384), point_t'((cx + h) * 16384),
                  point_t'((cx + h) * 16384), point_t'((cx - h) * 16384)};
        b.pt_y = {point_t'((cy + h) * 16384), point_t'((cy + h) * 16384),
                  point_t'((cy - h) * 16384), point_t'((cy - h) * 16384)};
        b.hw = half_t'(h);
        b.hh = half_t'(h);
        return b;
    endfunction

    task automatic drive_boxes(input box_t a, input box_t b);
        obb1_pos_x <= a.pos_x;
        obb1_pos_y <= a.pos_y;
        obb1_u_x <= a.u_x;
        obb1_u_y <= a.u_y;
        obb1_v_x <= a.v_x;
        obb1_v_y <= a.v_y;
        obb1_point0_x <= a.pt_x[0];
        obb1_point0_y <= a.pt_y[0];
        obb1_point1_x <= a.pt_x[1];
        obb1_point1_y <= a.pt_y[1];
        obb1_point2_x <= a.pt_x[2];
        obb1_point2_y <= a.pt_y[2];
        obb1_point3_x <= a.pt_x[3];
        obb1_point3_y <= a.pt_y[3];
        obb1_half_width <= a.hw;
        obb1_half_height <= a.hh;
        obb2_pos_x <= b.pos_x;
        obb2_pos_y <= b.pos_y;
        obb2_u_x <= b.u_x;
        obb2_u_y <= b.u_y;
        obb2_v_x <= b.v_x;
        obb2_v_y <= b.v_y;
        obb2_point0_x <= b.pt_x[0];
        obb2_point0_y <= b.pt_y[0];
        obb2_point1_x <= b.pt_x[1];
        obb2_point1_y <= b.pt_y[1];
        obb2_point2_x <= b.pt_x[2];
        obb2_point2_y <= b.pt_y[2];
        obb2_point3_x <= b.pt_x[3];
        obb2_point3_y <= b.pt_y[3];
        obb2_half_width <= b.hw;
        obb2_half_height <= b.hh;
    endtask

    // Holds in_valid until the accepting edge, then queues the expected contact
    task automatic send_request(input box_t a, input box_t b, input string name);
        logic hit;
        @(posedge clk);
        in_valid <= 1'b1;
        drive_boxes(a, b);
        do begin
            @(negedge clk);
            hit = in_ready;
            @(posedge clk);
        end while (!hit);
        in_valid <= 1'b0;
        exp_q.push_back(expected_contact(a, b));
        name_q.push_back(name);
    endtask

    // Result monitor with random back-pressure
    initial begin
        logic     busy;
        int       wait_left;
        int       errs_at_start;
        contact_t snap;
        contact_t exp;
        string    name;
        busy = 1'b0;
        errs_at_start = 0;
        // Stall for the next result, zero leaves out_ready high ahead of it
        wait_left = rand_word() % 9;
        @(posedge clk);
        out_ready <= (wait_left == 0);
        forever begin
            @(negedge clk);
            if (out_valid) begin
                if (!busy) begin
                    busy = 1'b1;
                    errs_at_start = errors;
                    snap = '{is_collision, penetration, normal_x, normal_y};
                end else begin
                    check_flag(is_collision, snap.coll, "held is_collision");
                    check_fixed(penetration, snap.pen, "held penetration");
                    check_axis(normal_x, snap.nx, "held normal_x");
                    check_axis(normal_y, snap.ny, "held normal_y");
                end
                check_flag(in_ready, 1'b0, "in_ready during result");
                if (out_ready) begin
                    busy = 1'b0;
                    if (exp_q.size() == 0) begin
                        $display("Result appeared with no request outstanding");
                        errors++;
                        name = "unexpected";
                    end else begin
                        exp = exp_q.pop_front();
                        name = name_q.pop_front();
                        check_flag(is_collision, exp.coll, "is_collision");
                        check_fixed(penetration, exp.pen, "penetration");
                        check_axis(normal_x, exp.nx, "normal_x");
                        check_axis(normal_y, exp.ny, "normal_y");
                    end
                    if (errors == errs_at_start) begin
                        pass_count++;
                        $display("ok   %s", name);
                    end else begin
                        fail_count++;
                        $display("bad  %s", name);
                    end
                    done_count++;
                    wait_left = rand_word() % 9;
                    @(posedge clk);
                    out_ready <= (wait_left == 0);
                end else begin
                    @(posedge clk);
                    wait_left--;
                    if (wait_left == 0) out_ready <= 1'b1;
                end
            end
        end
    end

    initial begin
        box_t     a;
        box_t     b;
        contact_t c;
        int       errs;
        clk = 1'b0;
        reset <= 1'b1;
        in_valid <= 1'b0;
        out_ready <= 1'b0;
        a = '0;
        drive_boxes(a, a);
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        errs = errors;
        check_flag(out_valid, 1'b0, "out_valid after reset");
        check_flag(in_ready, 1'b1, "in_ready after reset");
        if (errors == errs) begin
            pass_count++;
            $display("ok   reset state");
        end else begin
            fail_count++;
            $display("bad  reset state");
        end

        a = aligned_box(1, 0, 2);
        b = aligned_box(0, 0, 2);
        c = expected_contact(a, b);
        check_flag(c.coll, 1'b1, "overlap scenario flag");
        send_request(a, b, "overlapping boxes");

        a = aligned_box(10, 0, 2);
        c = expected_contact(a, b);
        check_flag(c.coll, 1'b0, "separated scenario flag");
        send_request(a, b, "separated boxes");

        // Full tie keeps the pass A u axis on its min side
        c = expected_contact(b, b);
        check_axis(c.nx, -16'sh4000, "tie normal_x");
        check_axis(c.ny, 16'sh0000, "tie normal_y");
        check_fixed(c.pen, fixed_t'(4 << 24), "tie penetration");
        send_request(b, b, "identical boxes");

        for (int n = 0; n < NUM_RANDOM; n++) begin
            a = random_box();
            b = random_box();
            send_request(a, b, $sformatf("random %0d", n));
        end

        while (done_count < NUM_VECTORS) @(posedge clk);
        repeat (4) @(negedge clk);
        check_flag(out_valid, 1'b0, "out_valid after last result");
        if (exp_q.size() != 0) begin
            $display("%0d expected results never arrived", exp_q.size());
            errors++;
        end
        $display("Tests passed %0d, failed %0d, check errors %0d",
                 pass_count, fail_count, errors);
        if (errors == 0 && fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verif
common/collision_pkg.sv
projection/obb_projector.sv
projection/axis_penetration.sv
design/contact_select.sv
design/collision_ctrl.sv
design/collision_detector.sv
verif/tb_collision_detector.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
    --top-module tb_collision_detector \
    -f compile.f \
    -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST PASSED" sim.log; then
    exit 0
fi
exit 1
